// File: tb.f
+incdir+common
+incdir+testbench
common/aes_pkg.sv
source/engine_ctrl.sv
aes_core/key_expansion_stage.sv
aes_core/aes_round.sv
aes_core/encrypt_engine.sv
source/aes_top.sv
testbench/clk_gen.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_top
RTL_TOP   ?= aes_top
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ns
JOBS      ?= 4
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// AES-128 encryption of one block with the state bytes kept column by column
function automatic logic [`AES_BLOCK_W-1:0] aes_encrypt(
    input logic [`AES_BLOCK_W-1:0] pt,
    input logic [`AES_BLOCK_W-1:0] k
);
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [7:0] rk [16];
    logic [7:0] tmp [4];
    logic [7:0] a0, a1, a2, a3;
    logic [`AES_BLOCK_W-1:0] ct;
    for (int n = 0; n < 16; n++) begin
        rk[n] = k[`AES_BLOCK_W-1-8*n -: 8];
        s[n]  = pt[`AES_BLOCK_W-1-8*n -: 8] ^ rk[n];
    end
    for (int round = 1; round <= 10; round++) begin
        tmp[0] = sbox(rk[13]) ^ rcon(round);   // RotWord then SubWord of the last word
        tmp[1] = sbox(rk[14]);
        tmp[2] = sbox(rk[15]);
        tmp[3] = sbox(rk[12]);
        for (int j = 0; j < 4; j++) rk[j] = rk[j] ^ tmp[j];
        for (int n = 4; n < 16; n++) rk[n] = rk[n] ^ rk[n-4];
        // Byte in row r moves r columns to the left
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) t[4*((c+4-r)%4)+r] = sbox(s[4*c+r]);
        end
        for (int c = 0; c < 4; c++) begin
            a0 = t[4*c];
            a1 = t[4*c+1];
            a2 = t[4*c+2];
            a3 = t[4*c+3];
            if (round < 10) begin
                t[4*c]   = xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3;
                t[4*c+1] = a0 ^ xtime(a1 ^ a2) ^ a2 ^ a3;
                t[4*c+2] = a0 ^ a1 ^ xtime(a2 ^ a3) ^ a3;
                t[4*c+3] = xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2;
            end
        end
        for (int n = 0; n < 16; n++) s[n] = t[n] ^ rk[n];
    end
    for (int n = 0; n < 16; n++) ct[`AES_BLOCK_W-1-8*n -: 8] = s[n];
    return ct;
endfunction

`endif

// File: testbench/tb_top.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module tb_top;
    import aes_pkg::*;

    `include "aes_model.svh"

    localparam logic [`AES_BLOCK_W-1:0] fips_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [`AES_BLOCK_W-1:0] fips_pt  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [`AES_BLOCK_W-1:0] fips_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam int n_stream  = 200;
    localparam int n_gapped  = 120;
    localparam int n_protect = 20;
    localparam int n_rekey   = 50;
    localparam int watchdog_cycles = 2 * (n_stream + n_gapped + n_protect + n_rekey)
                                   + 6 * (`AES_KEY_SETTLE + `AES_ROUNDS) + 100;

    logic clk, rst_n;
    logic start, set_key, halt;
    logic [`AES_BLOCK_W-1:0] state, key, out;
    logic out_valid, ready;

    logic [31:0] lfsr = 32'h7431_1965;
    logic [`AES_BLOCK_W-1:0] active_key;   // Key the engine should be holding
    logic [`AES_BLOCK_W-1:0] exp_q [$];
    int acc_q [$];                         // Edge at which each block was accepted
    int cycle = 0;

    clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    aes_top dut_i (
        .clk (clk), .rst_n (rst_n), .start (start), .set_key (set_key), .halt (halt),
        .state (state), .key (key), .out (out), .out_valid (out_valid), .ready (ready)
    );

    function automatic logic next_bit();
        logic out_bit;
        out_bit = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out_bit ? 32'h8020_0003 : 32'h0);
        return out_bit;
    endfunction

    function automatic logic [`AES_BLOCK_W-1:0] rand_block();
        logic [`AES_BLOCK_W-1:0] v;
        v = '0;
        for (int i = 0; i < `AES_BLOCK_W; i++) v[i] = next_bit();
        return v;
    endfunction

    task automatic report_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    always @(posedge clk) cycle <= cycle + 1;   // After edge n the count reads n

    // Checks each result, then records the block that the next edge accepts
    always @(negedge clk) begin : compare_results
        logic [`AES_BLOCK_W-1:0] exp_val;
        int acc_edge;
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid rose at cycle %0d with no block in flight", cycle);
                    report_failure();
                end
                exp_val  = exp_q.pop_front();
                acc_edge = acc_q.pop_front();
                assert (out == exp_val) else begin
                    $display("ERR out: got %h expected %h", out, exp_val);
                    report_failure();
                end
                assert (cycle - acc_edge == `AES_ROUNDS) else begin
                    $display("ERR out_valid: latency %h expected %h", cycle - acc_edge,
                             `AES_ROUNDS);
                    report_failure();
                end
            end
            if (start && ready) begin
                exp_q.push_back(aes_encrypt(state, active_key));
                acc_q.push_back(cycle + 1);
            end
        end
    end

    task automatic load_key(input logic [`AES_BLOCK_W-1:0] new_key);
        int set_edge;
        int waited;
        @(posedge clk);
        key        <= new_key;
        set_key    <= 1'b1;
        start      <= 1'b0;
        active_key = new_key;
        @(negedge clk);
        set_edge = cycle + 1;
        @(posedge clk);
        set_key <= 1'b0;
        key     <= rand_block();   // Only the loaded value may matter
        @(negedge clk);
        waited = 0;
        while (!ready && waited <= `AES_KEY_SETTLE) begin
            @(posedge clk);
            start <= next_bit();   // Ignored while the chain settles
            state <= rand_block();
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            $display("ready never rose after the key load at cycle %0d", set_edge);
            report_failure();
        end
        assert (cycle == set_edge + `AES_KEY_SETTLE) else begin
            $display("ERR ready: rose at cycle %h expected %h", cycle,
                     set_edge + `AES_KEY_SETTLE);
            report_failure();
        end
    endtask

    task automatic stream_blocks(input int count, input bit gapped);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            state <= rand_block();
            start <= gapped ? next_bit() : 1'b1;
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < `AES_ROUNDS + 4) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d blocks still missing after draining the pipeline", exp_q.size());
            report_failure();
        end
    endtask

    initial begin
        start      <= 1'b0;
        set_key    <= 1'b0;
        halt       <= 1'b0;
        state      <= '0;
        key        <= '0;
        active_key = '0;
        @(posedge rst_n);
        @(negedge clk);
        assert (!ready && !out_valid) else begin
            $display("ERR ready/out_valid: got %h/%h expected 0/0", ready, out_valid);
            report_failure();
        end
        stream_blocks(4, 1'b0);   // Nothing may come out of MODE_INIT
        assert (aes_encrypt(fips_pt, fips_key) == fips_ct) else begin
            $display("ERR aes_encrypt: got %h expected %h", aes_encrypt(fips_pt, fips_key),
                     fips_ct);
            report_failure();
        end
        load_key(fips_key);
        @(posedge clk);
        state <= fips_pt;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        drain_pipeline();
        stream_blocks(n_stream, 1'b0);
        drain_pipeline();
        stream_blocks(n_gapped, 1'b1);
        drain_pipeline();
        // A new key in MODE_PROCESS must not reach the engine
        @(posedge clk);
        key     <= rand_block();
        set_key <= 1'b1;
        @(posedge clk);
        set_key <= 1'b0;
        stream_blocks(n_protect, 1'b0);
        drain_pipeline();
        @(posedge clk);
        halt <= 1'b1;
        @(posedge clk);
        halt <= 1'b0;
        @(negedge clk);
        assert (!ready) else begin
            $display("ERR ready: got %h expected 0 after halt", ready);
            report_failure();
        end
        load_key(rand_block());
        stream_blocks(n_rekey, 1'b0);
        drain_pipeline();
        if (exp_q.size() != 0) begin
            $display("%0d accepted blocks produced no result", exp_q.size());
            report_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        report_failure();
    end

endmodule

// File: testbench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
    parameter int half_period  = 2,   // 4 ns clock period
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;   // Released on a rising edge
    end

endmodule

// File: source/aes_top.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    set_key,
    input  logic                    halt,
    input  logic [`AES_BLOCK_W-1:0] state,
    input  logic [`AES_BLOCK_W-1:0] key,
    output logic [`AES_BLOCK_W-1:0] out,
    output logic                    out_valid,
    output logic                    ready
);

    logic [`AES_BLOCK_W-1:0] key_value;   // Key held by the control block
    logic                    accept;

    engine_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .set_key   (set_key),
        .halt      (halt),
        .key       (key),
        .key_value (key_value),
        .accept    (accept),
        .ready     (ready)
    );

    encrypt_engine engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .state     (state),
        .key_value (key_value),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

// File: aes_core/encrypt_engine.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module encrypt_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  logic [`AES_BLOCK_W-1:0] state,
    input  logic [`AES_BLOCK_W-1:0] key_value,
    output logic [`AES_BLOCK_W-1:0] out,
    output logic                    out_valid
);

    // Index 0 is the input register, index r is the output of round r
    logic [`AES_BLOCK_W-1:0] round_state [`AES_ROUNDS+1];
    logic                    round_valid [`AES_ROUNDS+1];
    // Entry g holds the round key used by round g+1
    logic [`AES_BLOCK_W-1:0] round_key [`AES_ROUNDS];

    always_ff @(posedge clk) begin
        if (accept) begin
            round_state[0] <= state ^ key_value;   // Initial AddRoundKey
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_valid[0] <= 1'b0;
        end else begin
            round_valid[0] <= accept;   // One pulse per accepted block
        end
    end

    for (genvar g = 0; g < `AES_ROUNDS; g++) begin : g_key_chain
        if (g == 0) begin : g_first
            key_expansion_stage #(
                .round_idx (g)
            ) key_stage_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .in_key  (key_value),
                .out_key (round_key[g])
            );
        end else begin : g_next
            key_expansion_stage #(
                .round_idx (g)
            ) key_stage_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .in_key  (round_key[g-1]),
                .out_key (round_key[g])
            );
        end
    end

    for (genvar g = 0; g < `AES_ROUNDS; g++) begin : g_rounds
        aes_round #(
            .final_round (g == `AES_ROUNDS - 1)
        ) round_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .state     (round_state[g]),
            .in_valid  (round_valid[g]),
            .key       (round_key[g]),
            .out       (round_state[g+1]),
            .out_valid (round_valid[g+1])
        );
    end

    assign out       = round_state[`AES_ROUNDS];
    assign out_valid = round_valid[`AES_ROUNDS];

endmodule

// File: aes_core/aes_round.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_round #(
    parameter bit final_round = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AES_BLOCK_W-1:0] state,
    input  logic                    in_valid,
    input  logic [`AES_BLOCK_W-1:0] key,
    output logic [`AES_BLOCK_W-1:0] out,
    output logic                    out_valid
);
    import aes_pkg::*;

    logic [7:0] sub_b [16];     // Byte n is row n%4, column n/4
    logic [7:0] shift_b [16];
    logic [7:0] mix_b [16];
    logic [`AES_BLOCK_W-1:0] round_val;

    always_comb begin
        for (int n = 0; n < 16; n++) begin
            sub_b[n] = sbox(state[`AES_BLOCK_W-1-8*n -: 8]);
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_b[4*c+r] = sub_b[4*((c+r)%4)+r];   // Row r rotates left by r
            end
        end
    end

    always_comb begin : mix_columns
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = shift_b[4*c];
            a1 = shift_b[4*c+1];
            a2 = shift_b[4*c+2];
            a3 = shift_b[4*c+3];
            if (final_round) begin
                mix_b[4*c]   = a0;   // Last round skips MixColumns
                mix_b[4*c+1] = a1;
                mix_b[4*c+2] = a2;
                mix_b[4*c+3] = a3;
            end else begin
                mix_b[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
                mix_b[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
                mix_b[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
                mix_b[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
            end
        end
    end

    always_comb begin
        for (int n = 0; n < 16; n++) begin
            round_val[`AES_BLOCK_W-1-8*n -: 8] = mix_b[n] ^ key[`AES_BLOCK_W-1-8*n -: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= round_val;   // Data only moves with a block
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

// File: aes_core/key_expansion_stage.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module key_expansion_stage #(
    parameter int round_idx = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AES_BLOCK_W-1:0] in_key,
    output logic [`AES_BLOCK_W-1:0] out_key
);
    import aes_pkg::*;

    logic [31:0] w0, w1, w2, w3;
    logic [31:0] rot_w;
    logic [31:0] temp_w;
    logic [31:0] n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = in_key;   // w0 holds the leftmost key bytes

    assign rot_w  = {w3[23:0], w3[31:24]};   // RotWord
    assign temp_w = {sbox(rot_w[31:24]) ^ rcon(round_idx + 1),
                     sbox(rot_w[23:16]),
                     sbox(rot_w[15:8]),
                     sbox(rot_w[7:0])};

    // Each new word folds in the one before it
    assign n0 = w0 ^ temp_w;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_key <= '0;
        end else begin
            out_key <= {n0, n1, n2, n3};
        end
    end

endmodule

// File: source/engine_ctrl.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module engine_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    set_key,
    input  logic                    halt,
    input  logic [`AES_BLOCK_W-1:0] key,
    output logic [`AES_BLOCK_W-1:0] key_value,
    output logic                    accept,
    output logic                    ready
);
    import aes_pkg::*;

    localparam int settle_w = $clog2(`AES_KEY_SETTLE + 1);

    engine_mode_e mode, next_mode;
    logic [settle_w-1:0] settle_cnt;
    logic settle_done;

    assign settle_done = (settle_cnt == settle_w'(`AES_KEY_SETTLE - 1));

    always_comb begin
        next_mode = mode;
        case (mode)
            MODE_INIT:    if (set_key) next_mode = MODE_EXPAND;
            MODE_EXPAND:  if (settle_done) next_mode = MODE_READY;
            MODE_READY:   if (start) next_mode = MODE_PROCESS;
            MODE_PROCESS: if (halt) next_mode = MODE_INIT;
            default:      next_mode = MODE_INIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode       <= MODE_INIT;
            settle_cnt <= '0;
            key_value  <= '0;
        end else begin
            mode <= next_mode;
            if (mode == MODE_EXPAND) begin
                settle_cnt <= settle_cnt + 1'b1;   // One stage of the key chain fills per cycle
            end else begin
                settle_cnt <= '0;
            end
            if (mode == MODE_INIT && set_key) begin
                key_value <= key;                  // Key stays frozen outside MODE_INIT
            end
        end
    end

    assign ready  = (mode == MODE_READY) || (mode == MODE_PROCESS);
    assign accept = start && ready;

endmodule

// File: common/aes_pkg.sv
package aes_pkg;

    typedef enum logic [1:0] {
        MODE_INIT,     // Waiting for a key
        MODE_EXPAND,   // Key chain is being refilled
        MODE_READY,    // Round keys valid, no block accepted yet
        MODE_PROCESS   // Streaming blocks
    } engine_mode_e;

    // Forward S-box with entry 0 in the leftmost byte
    localparam logic [0:255][7:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_table[b];
    endfunction

    // Round constant for key schedule step idx, counted from 1
    function automatic logic [7:0] rcon(input int idx);
        case (idx)
            1:       return 8'h01;
            2:       return 8'h02;
            3:       return 8'h04;
            4:       return 8'h08;
            5:       return 8'h10;
            6:       return 8'h20;
            7:       return 8'h40;
            8:       return 8'h80;
            9:       return 8'h1b;
            10:      return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);   // Reduce by x^8+x^4+x^3+x+1
    endfunction

endpackage

// File: common/aes_settings.svh
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// Width of one data block and of the AES-128 cipher key
`define AES_BLOCK_W 128

`define AES_ROUNDS 10

// Every round key is valid once the key chain has been refilled
`define AES_KEY_SETTLE `AES_ROUNDS

`endif
